// ==== include/speech_fe_defs.svh ====
`ifndef SPEECH_FE_DEFS_SVH
`define SPEECH_FE_DEFS_SVH

// Number of audio channels, one frame lane each
`define FE_CHANNELS 4

// Samples per frame
`define FE_FRAME_LEN 32

// New samples between the starts of consecutive frames
`define FE_HOP 16

// Pre-emphasis coefficient 0.97 in Q15
`define FE_PREEMPH_Q15 16'h7C29

`endif

// ==== logic/speech_fe_pkg.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

package speech_fe_pkg;

    localparam real PI = 3.14159265358979323846;

    // Q15 audio sample
    typedef logic signed [15:0] sample_t;

    typedef logic [$clog2(`FE_CHANNELS)-1:0] chan_t;

    // Position within a frame
    typedef logic [$clog2(`FE_FRAME_LEN)-1:0] idx_t;

    // Tagged input word
    typedef struct packed {
        chan_t   chan;
        sample_t sample;
    } in_sample_s;

    // One windowed output word
    typedef struct packed {
        chan_t   chan;
        idx_t    index;
        logic    last;
        sample_t sample;
    } win_sample_s;

    // Hamming coefficient k in Q15, rounded to nearest
    function automatic sample_t hamming_coef(input int k);
        real w;
        w = 0.54 - 0.46 * $cos(2.0 * PI * real'(k) / real'(`FE_FRAME_LEN - 1));
        // Window is always positive, so adding a half rounds to nearest
        return sample_t'($rtoi(32767.0 * w + 0.5));
    endfunction

endpackage

`default_nettype wire

// ==== logic/sample_router.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

module sample_router (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  speech_fe_pkg::in_sample_s   in_data,
    output logic [`FE_CHANNELS-1:0]     lane_wr,
    output speech_fe_pkg::sample_t      lane_sample
);

    logic [`FE_CHANNELS-1:0] wr_dec;
    logic                    tag_ok;

    // Tags beyond the last lane are dropped
    assign tag_ok = int'(in_data.chan) < `FE_CHANNELS;

    always_comb begin
        wr_dec = '0;
        if (in_valid && tag_ok) begin
            wr_dec[in_data.chan] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_wr <= '0;
        end else begin
            lane_wr <= wr_dec;
        end
    end

    // Shared sample bus, qualified by lane_wr
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_sample <= in_data.sample;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_lane.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

module frame_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr,
    input  speech_fe_pkg::sample_t  wr_sample,
    input  logic                    grant,
    output logic                    frame_ready,
    output logic                    rd_valid,
    output speech_fe_pkg::sample_t  rd_sample,
    output speech_fe_pkg::idx_t     rd_index,
    output logic                    rd_last,
    output logic                    overrun
);
    import speech_fe_pkg::*;

    localparam int      RING_LEN = 2 * `FE_FRAME_LEN;
    localparam int      PTR_W    = $clog2(RING_LEN);
    localparam sample_t PREEMPH  = sample_t'(`FE_PREEMPH_Q15);

    typedef logic [PTR_W-1:0] ptr_t;

    sample_t ring [RING_LEN];
    sample_t coef_rom [`FE_FRAME_LEN];

    sample_t prev_sample;
    ptr_t    wr_ptr;
    ptr_t    base_ptr;
    idx_t    hop_cnt;
    logic    first_done;
    logic    frame_done;
    logic    accept;

    logic signed [31:0] pe_prod;
    logic signed [16:0] pe_shift;
    logic signed [16:0] pe_diff;
    sample_t            pe_out;

    idx_t               fetch_k;
    ptr_t               fetch_ptr;
    logic signed [31:0] win_prod;

    // Window table, fixed at elaboration
    for (genvar k = 0; k < `FE_FRAME_LEN; k++) begin : g_coef
        localparam sample_t COEF = hamming_coef(k);
        assign coef_rom[k] = COEF;
    end

    // y(n) = x(n) - a*x(n-1), saturated
    always_comb begin
        pe_prod  = PREEMPH * prev_sample;
        pe_shift = 17'(pe_prod >>> 15);
        pe_diff  = 17'(wr_sample) - pe_shift;
        if (pe_diff[16] != pe_diff[15]) begin
            pe_out = pe_diff[16] ? 16'sh8000 : 16'sh7FFF;
        end else begin
            pe_out = pe_diff[15:0];
        end
    end

    // First frame needs a full frame of samples, later ones a hop
    assign frame_done = wr && (first_done ? (hop_cnt == idx_t'(`FE_HOP - 1))
                                          : (hop_cnt == idx_t'(`FE_FRAME_LEN - 1)));

    // A frame completing while the last one is pending or in readout is lost
    assign accept = frame_done && !frame_ready && !rd_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_sample <= '0;
            wr_ptr      <= '0;
            hop_cnt     <= '0;
            first_done  <= 1'b0;
        end else if (wr) begin
            prev_sample <= wr_sample;
            wr_ptr      <= wr_ptr + 1'b1;
            if (frame_done) begin
                hop_cnt    <= '0;
                first_done <= 1'b1;
            end else begin
                hop_cnt <= hop_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            ring[wr_ptr] <= pe_out;
        end
    end

    // Oldest sample of the new frame
    always_ff @(posedge clk) begin
        if (accept) begin
            base_ptr <= wr_ptr - ptr_t'(`FE_FRAME_LEN - 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_ready <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (accept) begin
                frame_ready <= 1'b1;
            end else if (grant) begin
                frame_ready <= 1'b0;
            end
            if (frame_done && (frame_ready || rd_valid)) begin
                overrun <= 1'b1;
            end
        end
    end

    // Next window position to fetch
    assign fetch_k   = rd_valid ? rd_index + 1'b1 : '0;
    assign fetch_ptr = base_ptr + ptr_t'(fetch_k);
    assign win_prod  = ring[fetch_ptr] * coef_rom[fetch_k];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_index <= '0;
            rd_last  <= 1'b0;
        end else if (grant) begin
            rd_valid <= 1'b1;
            rd_index <= '0;
            rd_last  <= 1'b0;
        end else if (rd_valid) begin
            rd_valid <= !rd_last;
            rd_index <= rd_index + 1'b1;
            rd_last  <= !rd_last && (rd_index == idx_t'(`FE_FRAME_LEN - 2));
        end
    end

    always_ff @(posedge clk) begin
        if (grant || rd_valid) begin
            rd_sample <= win_prod[30:15];
        end
    end

endmodule

`default_nettype wire

// ==== logic/frame_arbiter.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

module frame_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`FE_CHANNELS-1:0]     frame_ready,
    output logic [`FE_CHANNELS-1:0]     grant,
    input  logic [`FE_CHANNELS-1:0]     rd_valid,
    input  speech_fe_pkg::sample_t      rd_sample [`FE_CHANNELS],
    input  speech_fe_pkg::idx_t         rd_index [`FE_CHANNELS],
    input  logic [`FE_CHANNELS-1:0]     rd_last,
    output logic                        out_valid,
    output speech_fe_pkg::win_sample_s  out_data
);
    import speech_fe_pkg::*;

    localparam int N = `FE_CHANNELS;

    logic  busy;
    chan_t cur;
    chan_t cand;
    chan_t pick;
    logic  found;
    logic  start;
    logic  stream_last;

    // Search starts at the lane after the one served last
    always_comb begin
        pick  = cur;
        cand  = cur;
        found = 1'b0;
        for (int i = 1; i <= N; i++) begin
            cand = chan_t'((int'(cur) + i) % N);
            if (!found && frame_ready[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign start       = !busy && found;
    assign stream_last = rd_valid[cur] && rd_last[cur];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cur       <= chan_t'(N - 1);
            grant     <= '0;
            out_valid <= 1'b0;
        end else begin
            grant     <= '0;
            out_valid <= busy && rd_valid[cur];
            if (start) begin
                busy        <= 1'b1;
                cur         <= pick;
                grant[pick] <= 1'b1;
            end else if (busy && stream_last) begin
                busy <= 1'b0;
            end
        end
    end

    // Granted lane's stream, tagged with its channel
    always_ff @(posedge clk) begin
        if (busy && rd_valid[cur]) begin
            out_data.chan   <= cur;
            out_data.index  <= rd_index[cur];
            out_data.last   <= rd_last[cur];
            out_data.sample <= rd_sample[cur];
        end
    end

endmodule

`default_nettype wire

// ==== logic/speech_fe_top.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

module speech_fe_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  speech_fe_pkg::in_sample_s   in_data,
    output logic                        out_valid,
    output speech_fe_pkg::win_sample_s  out_data,
    output logic [`FE_CHANNELS-1:0]     overrun
);
    import speech_fe_pkg::*;

    logic [`FE_CHANNELS-1:0] lane_wr;
    sample_t                 lane_sample;
    logic [`FE_CHANNELS-1:0] frame_ready;
    logic [`FE_CHANNELS-1:0] grant;
    logic [`FE_CHANNELS-1:0] rd_valid;
    logic [`FE_CHANNELS-1:0] rd_last;
    sample_t                 rd_sample [`FE_CHANNELS];
    idx_t                    rd_index [`FE_CHANNELS];

    sample_router u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .lane_wr     (lane_wr),
        .lane_sample (lane_sample)
    );

    // One framing lane per channel
    for (genvar i = 0; i < `FE_CHANNELS; i++) begin : g_lane
        frame_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr          (lane_wr[i]),
            .wr_sample   (lane_sample),
            .grant       (grant[i]),
            .frame_ready (frame_ready[i]),
            .rd_valid    (rd_valid[i]),
            .rd_sample   (rd_sample[i]),
            .rd_index    (rd_index[i]),
            .rd_last     (rd_last[i]),
            .overrun     (overrun[i])
        );
    end

    frame_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .grant       (grant),
        .rd_valid    (rd_valid),
        .rd_sample   (rd_sample),
        .rd_index    (rd_index),
        .rd_last     (rd_last),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// ==== tests/speech_fe_tb.sv ====
`default_nettype none

`include "speech_fe_defs.svh"

module speech_fe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import speech_fe_pkg::*;

    localparam int NCH        = `FE_CHANNELS;
    localparam int FLEN       = `FE_FRAME_LEN;
    localparam int HOP        = `FE_HOP;
    localparam int WAIT_LIMIT = 2000;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    in_sample_s     in_data;
    logic           out_valid;
    win_sample_s    out_data;
    logic [NCH-1:0] overrun;

    // Reference model state per channel
    int          win_tab [FLEN];
    int          prev_x [NCH];
    int          n_in [NCH];
    int          hist [NCH][$];
    sample_t     exp_q [NCH][$];

    win_sample_s rx_q [$];
    win_sample_s blk [FLEN];
    int          served [NCH];

    int n_checks;
    int n_errors;
    int n_fails;

    speech_fe_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .overrun   (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output words are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            rx_q.push_back(out_data);
        end
    end

    function automatic void build_window();
        real pi;
        real w;
        pi = 3.14159265358979323846;
        for (int k = 0; k < FLEN; k++) begin
            w = 0.54 - 0.46 * $cos(2.0 * pi * k / (FLEN - 1));
            win_tab[k] = $rtoi(32767.0 * w + 0.5);
        end
    endfunction

    function automatic sample_t window_word(input int y, input int k);
        int prod;
        prod = y * win_tab[k];
        return sample_t'(prod >>> 15);
    endfunction

    function automatic void model_reset();
        for (int c = 0; c < NCH; c++) begin
            prev_x[c] = 0;
            n_in[c]   = 0;
            hist[c].delete();
            exp_q[c].delete();
        end
        rx_q.delete();
    endfunction

    // Pre-emphasis and a windowed frame every hop once the first frame is full
    function automatic void model_sample(input int ch, input int x);
        int d;
        d = x - ((int'(`FE_PREEMPH_Q15) * prev_x[ch]) >>> 15);
        if (d > 32767) begin
            d = 32767;
        end else if (d < -32768) begin
            d = -32768;
        end
        prev_x[ch] = x;
        hist[ch].push_back(d);
        if (hist[ch].size() > FLEN) begin
            void'(hist[ch].pop_front());
        end
        n_in[ch]++;
        if (n_in[ch] >= FLEN && (n_in[ch] - FLEN) % HOP == 0) begin
            for (int k = 0; k < FLEN; k++) begin
                exp_q[ch].push_back(window_word(hist[ch][k], k));
            end
        end
    endfunction

    function automatic int exp_words();
        int total;
        total = 0;
        for (int c = 0; c < NCH; c++) begin
            total += exp_q[c].size();
        end
        return total;
    endfunction

    function automatic sample_t rand_sample();
        return sample_t'($urandom);
    endfunction

    function automatic void take_block();
        for (int k = 0; k < FLEN; k++) begin
            blk[k] = rx_q.pop_front();
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Drive one tagged sample and hold the bus idle for the rest of the spacing
    task automatic send_sample(input int ch, input sample_t x, input int spacing);
        in_valid       = 1'b1;
        in_data.chan   = chan_t'(ch);
        in_data.sample = x;
        model_sample(ch, int'(x));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        quiet_cycles(spacing - 1);
    endtask

    task automatic wait_words(input int n, input string what);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rx_q.size() < n) begin
            $display("Timeout in %s: only %0d of %0d output words arrived",
                     what, rx_q.size(), n);
            n_fails++;
        end
    endtask

    // Every delivered frame must be the next model frame of its channel
    task automatic check_frames();
        int ch;
        for (int c = 0; c < NCH; c++) begin
            served[c] = 0;
        end
        while (rx_q.size() >= FLEN) begin
            take_block();
            ch = int'(blk[0].chan);
            served[ch]++;
            if (exp_q[ch].size() < FLEN) begin
                $display("Unexpected frame came out on channel %0d", ch);
                n_fails++;
            end else begin
                for (int k = 0; k < FLEN; k++) begin
                    if (k > 0) begin
                        check_value($sformatf("out_data.chan (word %0d)", k),
                                    blk[k].chan, ch);
                    end
                    check_value($sformatf("out_data.index (chan %0d)", ch), blk[k].index, k);
                    check_value($sformatf("out_data.last (chan %0d, index %0d)", ch, k),
                                blk[k].last, k == FLEN - 1);
                    check_value($sformatf("out_data.sample (chan %0d, index %0d)", ch, k),
                                blk[k].sample, exp_q[ch].pop_front());
                end
            end
        end
        if (rx_q.size() != 0) begin
            $display("A partial frame of %0d words came out", rx_q.size());
            n_fails++;
            rx_q.delete();
        end
        for (int c = 0; c < NCH; c++) begin
            if (exp_q[c].size() != 0) begin
                $display("Channel %0d: %0d expected frames never came out", c,
                         exp_q[c].size() / FLEN);
                n_fails++;
                exp_q[c].delete();
            end
        end
    endtask

    // Dropped frames are skipped and delivered ones must match in order
    task automatic match_frames(input int ch);
        logic hit;
        while (rx_q.size() >= FLEN) begin
            take_block();
            hit = 1'b0;
            while (!hit && exp_q[ch].size() >= FLEN) begin
                hit = 1'b1;
                for (int k = 0; k < FLEN; k++) begin
                    if (blk[k].chan !== chan_t'(ch) || blk[k].index !== idx_t'(k) ||
                        blk[k].last !== (k == FLEN - 1) ||
                        blk[k].sample !== exp_q[ch][k]) begin
                        hit = 1'b0;
                    end
                end
                repeat (FLEN) begin
                    void'(exp_q[ch].pop_front());
                end
            end
            n_checks++;
            if (!hit) begin
                $display("Frame from channel %0d matches no later model frame", ch);
                n_fails++;
            end
        end
        if (rx_q.size() != 0) begin
            $display("A partial frame of %0d words came out", rx_q.size());
            n_fails++;
        end
        model_reset_queues();
    endtask

    function automatic void model_reset_queues();
        for (int c = 0; c < NCH; c++) begin
            exp_q[c].delete();
        end
        rx_q.delete();
    endfunction

    task automatic test_single_frame();
        for (int i = 0; i < FLEN; i++) begin
            send_sample(0, rand_sample(), 4);
        end
        wait_words(exp_words(), "test_single_frame");
        quiet_cycles(2 * FLEN);
        check_value("out_valid word count", rx_q.size(), FLEN);
        check_frames();
    endtask

    task automatic test_overlap();
        int tail [HOP];
        for (int k = 0; k < HOP; k++) begin
            tail[k] = hist[0][FLEN - HOP + k];
        end
        for (int i = 0; i < HOP; i++) begin
            send_sample(0, rand_sample(), 4);
        end
        wait_words(exp_words(), "test_overlap");
        quiet_cycles(2 * FLEN);
        check_value("out_valid word count", rx_q.size(), FLEN);
        // Older half of the new frame repeats the newer half of the last one
        if (rx_q.size() >= HOP) begin
            for (int k = 0; k < HOP; k++) begin
                check_value($sformatf("out_data.sample overlap (index %0d)", k),
                            rx_q[k].sample, window_word(tail[k], k));
            end
        end
        check_frames();
    endtask

    task automatic test_interleaved();
        for (int i = 0; i < FLEN; i++) begin
            for (int c = 0; c < NCH; c++) begin
                send_sample(c, rand_sample(), 8);
            end
        end
        wait_words(exp_words(), "test_interleaved");
        quiet_cycles(2 * FLEN);
        check_frames();
        check_value("overrun", overrun, '0);
    endtask

    task automatic test_arbitration();
        for (int i = 0; i < HOP; i++) begin
            for (int c = 0; c < NCH; c++) begin
                send_sample(c, rand_sample(), 2);
            end
        end
        wait_words(NCH * FLEN, "test_arbitration");
        quiet_cycles(2 * FLEN);
        check_frames();
        for (int c = 0; c < NCH; c++) begin
            check_value($sformatf("frames served on channel %0d", c), served[c], 1);
        end
        check_value("overrun", overrun, '0);
    endtask

    task automatic test_overrun();
        for (int i = 0; i < 80; i++) begin
            send_sample(2, rand_sample(), 1);
        end
        // A readout spans more than two hops so only every third frame gets through
        wait_words(2 * FLEN, "test_overrun");
        quiet_cycles(2 * FLEN);
        check_value("overrun", overrun, 4'b0100);
        match_frames(2);
    endtask

    task automatic test_reset_history();
        sample_t x0;
        for (int i = 0; i < 20; i++) begin
            send_sample(1, rand_sample(), 2);
        end
        rst_n = 1'b0;
        quiet_cycles(3);
        check_value("overrun", overrun, '0);
        check_value("out_valid", out_valid, 1'b0);
        rst_n = 1'b1;
        model_reset();
        quiet_cycles(2);
        x0 = rand_sample();
        send_sample(1, x0, 3);
        for (int i = 1; i < FLEN; i++) begin
            send_sample(1, rand_sample(), 3);
        end
        wait_words(exp_words(), "test_reset_history");
        quiet_cycles(2 * FLEN);
        check_value("out_valid word count", rx_q.size(), FLEN);
        // With x(-1) = 0 the first output is just the windowed raw sample
        if (rx_q.size() > 0) begin
            check_value("out_data.sample after reset", rx_q[0].sample, window_word(x0, 0));
        end
        check_frames();
    endtask

    initial begin
        in_valid = 1'b0;
        in_data  = '0;
        rst_n    = 1'b0;
        n_checks = 0;
        n_errors = 0;
        n_fails  = 0;
        void'($urandom(32'he51e));
        build_window();
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        quiet_cycles(2);

        test_single_frame();
        test_overlap();
        test_interleaved();
        test_arbitration();
        test_overrun();
        test_reset_history();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 n_checks, n_errors, n_fails);
        if (n_errors == 0 && n_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
logic/speech_fe_pkg.sv
logic/sample_router.sv
logic/frame_lane.sv
logic/frame_arbiter.sv
logic/speech_fe_top.sv
tests/speech_fe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := speech_fe_tb
RTL_TOP   := speech_fe_top
FILELIST  := project.f
VFLAGS    := --binary --timing -j 0 -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(FILELIST) $(wildcard include/*.svh logic/*.sv tests/*.sv)
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
